// File: src/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Widths
`define CSR_DATA_W          32
`define CSR_NUM_W           14
`define CSR_ECODE_W         6
`define CSR_ESUB_W          9

// CRMD and PRMD fields
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_CRMD_DA         3
`define CSR_CRMD_PG         4
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2

// ECFG and ESTAT fields
`define CSR_ECFG_LIE        12:0
`define CSR_ESTAT_IS        12:0
`define CSR_ESTAT_IS_SW     1:0
`define CSR_ESTAT_IS_HW     9:2
`define CSR_ESTAT_IS_TI     11
`define CSR_ESTAT_IS_IPI    12
`define CSR_ESTAT_ECODE     21:16
`define CSR_ESTAT_ESUBCODE  30:22
`define CSR_EENTRY_VA       31:6

// Timer fields
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIODIC   1
`define CSR_TCFG_INITVAL    31:2
`define CSR_TICLR_CLR       0
`define CSR_TIMER_IDLE      32'hffff_ffff

`endif

// File: src/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

    typedef enum logic [`CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef enum logic [`CSR_ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    // One software write from the pipeline
    typedef struct packed {
        logic                   we;
        csr_num_e               num;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wvalue;
    } csr_write_t;

    // Exception entry reported by writeback
    typedef struct packed {
        logic                   ex;
        ecode_e                 ecode;
        logic [`CSR_ESUB_W-1:0] esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
        logic                   badv_is_pc;
    } exc_event_t;

    function automatic logic [`CSR_DATA_W-1:0] csr_merge(
        input logic [`CSR_DATA_W-1:0] old_value,
        input logic [`CSR_DATA_W-1:0] wmask,
        input logic [`CSR_DATA_W-1:0] wvalue
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

// File: src/csr_exc_regs.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_exc_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_pkg::csr_write_t    wr,
    input  csr_pkg::exc_event_t    exc,
    input  logic                   ertn,
    input  logic [7:0]             hw_int,
    input  logic                   ipi_int,
    input  logic                   timer_int,
    output logic [`CSR_DATA_W-1:0] crmd,
    output logic [`CSR_DATA_W-1:0] prmd,
    output logic [`CSR_DATA_W-1:0] ecfg,
    output logic [`CSR_DATA_W-1:0] estat,
    output logic [`CSR_DATA_W-1:0] era,
    output logic [`CSR_DATA_W-1:0] badv,
    output logic [`CSR_DATA_W-1:0] eentry,
    output logic                   has_int
);

    logic [1:0]              crmd_plv;
    logic                    crmd_ie;
    logic                    crmd_da;
    logic                    crmd_pg;
    logic [1:0]              prmd_pplv;
    logic                    prmd_pie;
    logic [12:0]             ecfg_lie;
    logic [1:0]              is_sw;
    logic [7:0]              is_hw;
    logic                    is_ipi;
    logic [`CSR_ECODE_W-1:0] estat_ecode;
    logic [`CSR_ESUB_W-1:0]  estat_esubcode;
    logic [`CSR_DATA_W-1:0]  era_pc;
    logic [`CSR_DATA_W-1:0]  badv_vaddr;
    logic [25:0]             eentry_va;

    logic                    wr_crmd;
    logic                    wr_prmd;
    logic                    wr_ecfg;
    logic                    wr_estat;
    logic                    wr_era;
    logic                    wr_eentry;
    logic [`CSR_DATA_W-1:0]  crmd_new;
    logic [`CSR_DATA_W-1:0]  prmd_new;
    logic [`CSR_DATA_W-1:0]  ecfg_new;
    logic [`CSR_DATA_W-1:0]  estat_new;
    logic [`CSR_DATA_W-1:0]  eentry_new;
    logic                    exc_addr_err;
    logic [11:0]             int_vec;

    assign wr_crmd   = wr.we && (wr.num == csr_pkg::CSR_CRMD);
    assign wr_prmd   = wr.we && (wr.num == csr_pkg::CSR_PRMD);
    assign wr_ecfg   = wr.we && (wr.num == csr_pkg::CSR_ECFG);
    assign wr_estat  = wr.we && (wr.num == csr_pkg::CSR_ESTAT);
    assign wr_era    = wr.we && (wr.num == csr_pkg::CSR_ERA);
    assign wr_eentry = wr.we && (wr.num == csr_pkg::CSR_EENTRY);

    // Register words after a masked software write
    assign crmd_new   = csr_pkg::csr_merge(crmd, wr.wmask, wr.wvalue);
    assign prmd_new   = csr_pkg::csr_merge(prmd, wr.wmask, wr.wvalue);
    assign ecfg_new   = csr_pkg::csr_merge(ecfg, wr.wmask, wr.wvalue);
    assign estat_new  = csr_pkg::csr_merge(estat, wr.wmask, wr.wvalue);
    assign eentry_new = csr_pkg::csr_merge(eentry, wr.wmask, wr.wvalue);

    // Only address errors carry a bad address
    assign exc_addr_err = (exc.ecode == csr_pkg::ECODE_ADE) ||
                          (exc.ecode == csr_pkg::ECODE_ALE);

    ////////////////////////////////////////////////////////////
    // Mode registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (exc.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_new[`CSR_CRMD_PLV];
            crmd_ie  <= crmd_new[`CSR_CRMD_IE];
        end
    end

    // DA comes out of reset set for direct address mode
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da <= 1'b1;
            crmd_pg <= 1'b0;
        end else if (wr_crmd) begin
            crmd_da <= crmd_new[`CSR_CRMD_DA];
            crmd_pg <= crmd_new[`CSR_CRMD_PG];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (exc.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= prmd_new[`CSR_PRMD_PPLV];
            prmd_pie  <= prmd_new[`CSR_PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= 13'b0;
        end else if (wr_ecfg) begin
            ecfg_lie <= ecfg_new[`CSR_ECFG_LIE];
        end
    end

    ////////////////////////////////////////////////////////////
    // Exception status and addresses
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            is_sw          <= 2'b0;
            is_hw          <= 8'b0;
            is_ipi         <= 1'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            if (wr_estat) begin
                is_sw <= estat_new[`CSR_ESTAT_IS_SW];
            end
            is_hw  <= hw_int;
            is_ipi <= ipi_int;
            if (exc.ex) begin
                estat_ecode    <= exc.ecode;
                estat_esubcode <= exc.esubcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era_pc <= '0;
        end else if (exc.ex) begin
            era_pc <= exc.pc;
        end else if (wr_era) begin
            era_pc <= csr_pkg::csr_merge(era_pc, wr.wmask, wr.wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badv_vaddr <= '0;
        end else if (exc.ex && exc_addr_err) begin
            badv_vaddr <= exc.badv_is_pc ? exc.pc : exc.vaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= 26'b0;
        end else if (wr_eentry) begin
            eentry_va <= eentry_new[`CSR_EENTRY_VA];
        end
    end

    // Register words as software sees them
    always_comb begin
        crmd = '0;
        crmd[`CSR_CRMD_PLV] = crmd_plv;
        crmd[`CSR_CRMD_IE]  = crmd_ie;
        crmd[`CSR_CRMD_DA]  = crmd_da;
        crmd[`CSR_CRMD_PG]  = crmd_pg;
        prmd = '0;
        prmd[`CSR_PRMD_PPLV] = prmd_pplv;
        prmd[`CSR_PRMD_PIE]  = prmd_pie;
        ecfg = '0;
        ecfg[`CSR_ECFG_LIE] = ecfg_lie;
        estat = '0;
        estat[`CSR_ESTAT_IS_SW]    = is_sw;
        estat[`CSR_ESTAT_IS_HW]    = is_hw;
        estat[`CSR_ESTAT_IS_TI]    = timer_int;
        estat[`CSR_ESTAT_IS_IPI]   = is_ipi;
        estat[`CSR_ESTAT_ECODE]    = estat_ecode;
        estat[`CSR_ESTAT_ESUBCODE] = estat_esubcode;
        eentry = '0;
        eentry[`CSR_EENTRY_VA] = eentry_va;
    end

    assign era  = era_pc;
    assign badv = badv_vaddr;

    // IPI bit 12 is not part of the pending check
    assign int_vec = estat[11:0] & ecfg_lie[11:0];
    assign has_int = (int_vec != 12'b0) && crmd_ie;

    a_exc_ertn_excl: assert property (@(posedge clk) disable iff (reset)
        !(exc.ex && ertn));

endmodule

// File: src/csr_timer.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_timer (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_pkg::csr_write_t    wr,
    output logic [`CSR_DATA_W-1:0] tcfg,
    output logic [`CSR_DATA_W-1:0] tval,
    output logic                   timer_int
);

    logic                   tcfg_en;
    logic                   tcfg_periodic;
    logic [29:0]            tcfg_initval;
    logic [`CSR_DATA_W-1:0] timer_cnt;
    logic [`CSR_DATA_W-1:0] tcfg_new;
    logic                   wr_tcfg;
    logic                   cnt_load;
    logic                   ticlr_clr;

    assign wr_tcfg  = wr.we && (wr.num == csr_pkg::CSR_TCFG);
    assign tcfg_new = csr_pkg::csr_merge(tcfg, wr.wmask, wr.wvalue);

    // A config write with EN set restarts the count
    assign cnt_load = wr_tcfg && tcfg_new[`CSR_TCFG_EN];

    assign ticlr_clr = wr.we && (wr.num == csr_pkg::CSR_TICLR) &&
                       wr.wmask[`CSR_TICLR_CLR] && wr.wvalue[`CSR_TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= 30'b0;
        end else if (wr_tcfg) begin
            tcfg_en       <= tcfg_new[`CSR_TCFG_EN];
            tcfg_periodic <= tcfg_new[`CSR_TCFG_PERIODIC];
            tcfg_initval  <= tcfg_new[`CSR_TCFG_INITVAL];
        end
    end

    ////////////////////////////////////////////////////////////
    // Down counter that parks at the idle value
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `CSR_TIMER_IDLE;
        end else if (cnt_load) begin
            timer_cnt <= {tcfg_new[`CSR_TCFG_INITVAL], 2'b00};
        end else if (tcfg_en && (timer_cnt != `CSR_TIMER_IDLE)) begin
            if (timer_cnt == '0) begin
                timer_cnt <= tcfg_periodic ? {tcfg_initval, 2'b00} : `CSR_TIMER_IDLE;
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Set beats clear
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (tcfg_en && (timer_cnt == '0)) begin
            timer_int <= 1'b1;
        end else if (ticlr_clr) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        tcfg = '0;
        tcfg[`CSR_TCFG_EN]       = tcfg_en;
        tcfg[`CSR_TCFG_PERIODIC] = tcfg_periodic;
        tcfg[`CSR_TCFG_INITVAL]  = tcfg_initval;
    end

    assign tval = timer_cnt;

    a_cnt_frozen: assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !cnt_load) |=> $stable(timer_cnt));

endmodule

// File: src/csr_save_bank.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_save_bank (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_pkg::csr_write_t    wr,
    input  csr_pkg::csr_num_e      rd_num,
    output logic [`CSR_DATA_W-1:0] save_rvalue
);

    logic [`CSR_DATA_W-1:0] save_q [4];
    logic                   wr_save;
    logic                   rd_save;

    // SAVE0..3 are consecutive so the low two bits pick the word
    assign wr_save = wr.we && (wr.num >= csr_pkg::CSR_SAVE0) &&
                     (wr.num <= csr_pkg::CSR_SAVE3);
    assign rd_save = (rd_num >= csr_pkg::CSR_SAVE0) && (rd_num <= csr_pkg::CSR_SAVE3);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr_save) begin
            save_q[wr.num[1:0]] <= csr_pkg::csr_merge(save_q[wr.num[1:0]],
                                                      wr.wmask, wr.wvalue);
        end
    end

    assign save_rvalue = rd_save ? save_q[rd_num[1:0]] : '0;

endmodule

// File: src/csr_top.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_top (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_pkg::csr_write_t    wr,
    input  csr_pkg::csr_num_e      rd_num,
    input  csr_pkg::exc_event_t    exc,
    input  logic                   ertn,
    input  logic [7:0]             hw_int,
    input  logic                   ipi_int,
    output logic [`CSR_DATA_W-1:0] rvalue,
    output logic [`CSR_DATA_W-1:0] era_entry,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic                   has_int
);

    logic [`CSR_DATA_W-1:0] crmd;
    logic [`CSR_DATA_W-1:0] prmd;
    logic [`CSR_DATA_W-1:0] ecfg;
    logic [`CSR_DATA_W-1:0] estat;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] eentry;
    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] tval;
    logic [`CSR_DATA_W-1:0] save_rvalue;
    logic                   timer_int;

    csr_exc_regs u_exc_regs (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .exc       (exc),
        .ertn      (ertn),
        .hw_int    (hw_int),
        .ipi_int   (ipi_int),
        .timer_int (timer_int),
        .crmd      (crmd),
        .prmd      (prmd),
        .ecfg      (ecfg),
        .estat     (estat),
        .era       (era),
        .badv      (badv),
        .eentry    (eentry),
        .has_int   (has_int)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_save_bank u_save_bank (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .rd_num      (rd_num),
        .save_rvalue (save_rvalue)
    );

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (rd_num)
            csr_pkg::CSR_CRMD:   rvalue = crmd;
            csr_pkg::CSR_PRMD:   rvalue = prmd;
            csr_pkg::CSR_ECFG:   rvalue = ecfg;
            csr_pkg::CSR_ESTAT:  rvalue = estat;
            csr_pkg::CSR_ERA:    rvalue = era;
            csr_pkg::CSR_BADV:   rvalue = badv;
            csr_pkg::CSR_EENTRY: rvalue = eentry;
            csr_pkg::CSR_SAVE0,
            csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2,
            csr_pkg::CSR_SAVE3:  rvalue = save_rvalue;
            csr_pkg::CSR_TCFG:   rvalue = tcfg;
            csr_pkg::CSR_TVAL:   rvalue = tval;
            // TICLR is write-only
            csr_pkg::CSR_TICLR:  rvalue = '0;
            default:             rvalue = '0;
        endcase
    end

    assign ex_entry  = eentry;
    assign era_entry = era;

endmodule

// File: tests/csr_tb.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_tb;

    logic                clk;
    logic                reset;
    csr_pkg::csr_write_t wr;
    csr_pkg::csr_num_e   rd_num;
    csr_pkg::exc_event_t exc;
    logic                ertn;
    logic [7:0]          hw_int;
    logic                ipi_int;
    logic [31:0]         rvalue;
    logic [31:0]         era_entry;
    logic [31:0]         ex_entry;
    logic                has_int;

    logic [15:0] lfsr;
    int          idx;
    logic [29:0] init;
    logic        periodic;

    // Reference model state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic        m_da;
    logic        m_pg;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [12:0] m_lie;
    logic [1:0]  m_is_sw;
    logic [7:0]  m_is_hw;
    logic        m_is_ipi;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_tcfg;
    logic [31:0] m_cnt;
    logic        m_tint;
    logic [31:0] m_save [4];
    logic [31:0] m_tcfg_new;
    logic        tcfg_wr;
    logic [31:0] exp_crmd;
    logic [31:0] exp_prmd;
    logic [31:0] exp_estat;
    logic        exp_has_int;

    csr_pkg::csr_num_e read_nums [21] = '{
        csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
        csr_pkg::CSR_ERA, csr_pkg::CSR_BADV, csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE0,
        csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3, csr_pkg::CSR_TCFG,
        csr_pkg::CSR_TVAL, csr_pkg::CSR_TICLR, csr_pkg::csr_num_e'(14'h002),
        csr_pkg::csr_num_e'(14'h003), csr_pkg::csr_num_e'(14'h008),
        csr_pkg::csr_num_e'(14'h034), csr_pkg::csr_num_e'(14'h040),
        csr_pkg::csr_num_e'(14'h043), csr_pkg::csr_num_e'(14'h3fff)
    };
    csr_pkg::csr_num_e write_nums [15] = '{
        csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
        csr_pkg::CSR_ERA, csr_pkg::CSR_BADV, csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE0,
        csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3, csr_pkg::CSR_TCFG,
        csr_pkg::CSR_TVAL, csr_pkg::CSR_TICLR, csr_pkg::csr_num_e'(14'h010)
    };
    csr_pkg::ecode_e ecodes [6] = '{
        csr_pkg::ECODE_INT, csr_pkg::ECODE_ADE, csr_pkg::ECODE_ALE,
        csr_pkg::ECODE_SYS, csr_pkg::ECODE_BRK, csr_pkg::ECODE_INE
    };

    csr_top dut (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .rd_num    (rd_num),
        .exc       (exc),
        .ertn      (ertn),
        .hw_int    (hw_int),
        .ipi_int   (ipi_int),
        .rvalue    (rvalue),
        .era_entry (era_entry),
        .ex_entry  (ex_entry),
        .has_int   (has_int)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] merged(logic [31:0] old, logic [31:0] mask,
                                           logic [31:0] val);
        return (val & mask) | (old & ~mask);
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    assign exp_crmd    = {27'b0, m_pg, m_da, m_ie, m_plv};
    assign exp_prmd    = {29'b0, m_pie, m_pplv};
    assign exp_estat   = {1'b0, m_esub, m_ecode, 3'b0, m_is_ipi, m_tint, 1'b0,
                          m_is_hw, m_is_sw};
    assign exp_has_int = ((exp_estat[11:0] & m_lie[11:0]) != 12'b0) && m_ie;
    assign m_tcfg_new  = merged(m_tcfg, wr.wmask, wr.wvalue);
    assign tcfg_wr     = wr.we && (wr.num == csr_pkg::CSR_TCFG);

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : model_update
        logic [31:0] wr_new;
        if (reset) begin
            {m_plv, m_ie, m_pg, m_pplv, m_pie, m_lie, m_is_sw} <= '0;
            {m_is_hw, m_is_ipi, m_ecode, m_esub, m_tint} <= '0;
            {m_era, m_badv, m_eentry, m_tcfg} <= '0;
            m_da  <= 1'b1;
            m_cnt <= `CSR_TIMER_IDLE;
            for (int i = 0; i < 4; i++) begin
                m_save[i] <= '0;
            end
        end else begin
            // Old word as software reads it, merged with the write
            wr_new   = merged(expected_read(wr.num), wr.wmask, wr.wvalue);
            m_is_hw  <= hw_int;
            m_is_ipi <= ipi_int;
            if (exc.ex) begin
                m_pplv  <= m_plv;
                m_pie   <= m_ie;
                m_plv   <= 2'b0;
                m_ie    <= 1'b0;
                m_ecode <= exc.ecode;
                m_esub  <= exc.esubcode;
                m_era   <= exc.pc;
                if (exc.ecode == csr_pkg::ECODE_ADE || exc.ecode == csr_pkg::ECODE_ALE) begin
                    m_badv <= exc.badv_is_pc ? exc.pc : exc.vaddr;
                end
            end else if (ertn) begin
                m_plv <= m_pplv;
                m_ie  <= m_pie;
            end else if (wr.we) begin
                case (wr.num)
                    csr_pkg::CSR_CRMD:
                        {m_pg, m_da, m_ie, m_plv} <= wr_new[4:0];
                    csr_pkg::CSR_PRMD:
                        {m_pie, m_pplv} <= wr_new[2:0];
                    csr_pkg::CSR_ECFG:
                        m_lie <= wr_new[12:0];
                    csr_pkg::CSR_ESTAT:
                        m_is_sw <= wr_new[1:0];
                    csr_pkg::CSR_ERA:
                        m_era <= wr_new;
                    csr_pkg::CSR_EENTRY:
                        m_eentry <= wr_new & 32'hffff_ffc0;
                    default: ;
                endcase
            end
            if (wr.we && wr.num >= csr_pkg::CSR_SAVE0 && wr.num <= csr_pkg::CSR_SAVE3) begin
                m_save[wr.num[1:0]] <= merged(m_save[wr.num[1:0]], wr.wmask, wr.wvalue);
            end
            if (tcfg_wr) begin
                m_tcfg <= m_tcfg_new;
            end
            if (tcfg_wr && m_tcfg_new[0]) begin
                m_cnt <= {m_tcfg_new[31:2], 2'b00};
            end else if (m_tcfg[0] && m_cnt != `CSR_TIMER_IDLE) begin
                if (m_cnt == 32'b0) begin
                    m_cnt <= m_tcfg[1] ? {m_tcfg[31:2], 2'b00} : `CSR_TIMER_IDLE;
                end else begin
                    m_cnt <= m_cnt - 1;
                end
            end
            if (m_tcfg[0] && m_cnt == 32'b0) begin
                m_tint <= 1'b1;
            end else if (wr.we && wr.num == csr_pkg::CSR_TICLR && wr.wmask[0] && wr.wvalue[0]) begin
                m_tint <= 1'b0;
            end
        end
    end

    function automatic logic [31:0] expected_read(csr_pkg::csr_num_e num);
        case (num)
            csr_pkg::CSR_CRMD:   return exp_crmd;
            csr_pkg::CSR_PRMD:   return exp_prmd;
            csr_pkg::CSR_ECFG:   return {19'b0, m_lie};
            csr_pkg::CSR_ESTAT:  return exp_estat;
            csr_pkg::CSR_ERA:    return m_era;
            csr_pkg::CSR_BADV:   return m_badv;
            csr_pkg::CSR_EENTRY: return m_eentry;
            csr_pkg::CSR_SAVE0,
            csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2,
            csr_pkg::CSR_SAVE3:  return m_save[num[1:0]];
            csr_pkg::CSR_TCFG:   return m_tcfg;
            csr_pkg::CSR_TVAL:   return m_cnt;
            default:             return 32'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and check tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_failed();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    // Must be called in the low clock phase
    task automatic check_read(csr_pkg::csr_num_e num);
        rd_num = num;
        #1;
        check_value($sformatf("rvalue[csr %h]", num), rvalue, expected_read(num));
        check_value("has_int", has_int, exp_has_int);
        check_value("era_entry", era_entry, m_era);
        check_value("ex_entry", ex_entry, m_eentry);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        wr.we  = 1'b0;
        exc.ex = 1'b0;
        ertn   = 1'b0;
    endtask

    task automatic op_write(csr_pkg::csr_num_e num, logic [31:0] mask, logic [31:0] val);
        next_cycle();
        wr.we     = 1'b1;
        wr.num    = num;
        wr.wmask  = mask;
        wr.wvalue = val;
    endtask

    task automatic wait_timer_int(int limit);
        int cycles;
        cycles = 0;
        rvalue_loop: while (1) begin
            next_cycle();
            check_read(csr_pkg::CSR_TVAL);
            check_read(csr_pkg::CSR_ESTAT);
            if (rvalue[`CSR_ESTAT_IS_TI]) begin
                break;
            end
            cycles++;
            if (cycles >= limit) begin
                $display("Timer interrupt did not rise within %0d cycles", limit);
                stop_failed();
            end
        end
    endtask

    initial begin
        int cycles;
        clk     = 1'b0;
        reset   = 1'b1;
        wr      = '0;
        rd_num  = csr_pkg::CSR_CRMD;
        exc     = '0;
        ertn    = 1'b0;
        hw_int  = 8'b0;
        ipi_int = 1'b0;
        lfsr    = 16'd8773;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Reset values
        next_cycle();
        check_read(csr_pkg::CSR_CRMD);
        check_value("rvalue[crmd]", rvalue, 32'h0000_0008);
        check_read(csr_pkg::CSR_TVAL);
        check_value("rvalue[tval]", rvalue, 32'hffff_ffff);
        check_value("has_int", has_int, 32'b0);
        for (int i = 0; i < 21; i++) begin
            next_cycle();
            check_read(read_nums[i]);
        end

        // Random masked writes
        repeat (40) begin
            idx = rand_bits(4) % 15;
            op_write(write_nums[idx], rand_bits(32), rand_bits(32));
            hw_int = rand_bits(8);
            check_read(read_nums[rand_bits(5) % 21]);
        end
        for (int i = 0; i < 21; i++) begin
            next_cycle();
            check_read(read_nums[i]);
        end

        ////////////////////////////////////////////////////////////
        // Exception entry and return
        ////////////////////////////////////////////////////////////
        repeat (12) begin
            op_write(csr_pkg::CSR_CRMD, 32'h7, rand_bits(3));
            next_cycle();
            exc.ex         = 1'b1;
            exc.ecode      = ecodes[rand_bits(3) % 6];
            exc.esubcode   = rand_bits(9);
            exc.pc         = rand_bits(32);
            exc.vaddr      = rand_bits(32);
            exc.badv_is_pc = rand_bits(1);
            next_cycle();
            check_read(csr_pkg::CSR_PRMD);
            check_read(csr_pkg::CSR_CRMD);
            check_read(csr_pkg::CSR_ESTAT);
            check_read(csr_pkg::CSR_BADV);
            check_value("era_entry", era_entry, exc.pc);
            next_cycle();
            ertn = 1'b1;
            next_cycle();
            check_read(csr_pkg::CSR_CRMD);
            check_read(csr_pkg::CSR_PRMD);
        end

        // Interrupt pending
        repeat (20) begin
            op_write(csr_pkg::CSR_ECFG, 32'hffff_ffff, rand_bits(13));
            op_write(csr_pkg::CSR_CRMD, 32'h4, rand_bits(1) << 2);
            op_write(csr_pkg::CSR_ESTAT, 32'h3, rand_bits(2));
            next_cycle();
            hw_int  = rand_bits(8);
            ipi_int = rand_bits(1);
            next_cycle();
            check_read(csr_pkg::CSR_ESTAT);
        end
        op_write(csr_pkg::CSR_ECFG, 32'hffff_ffff, 32'h0000_1fff);
        op_write(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
        hw_int = 8'hff;
        cycles = 0;
        while (!has_int) begin
            next_cycle();
            check_read(csr_pkg::CSR_ESTAT);
            cycles++;
            if (cycles >= 5) begin
                $display("has_int stayed low with interrupts enabled and pending");
                stop_failed();
            end
        end

        ////////////////////////////////////////////////////////////
        // Timer
        ////////////////////////////////////////////////////////////
        hw_int  = 8'b0;
        ipi_int = 1'b0;
        repeat (6) begin
            op_write(csr_pkg::CSR_TCFG, 32'hffff_ffff, 32'b0);
            op_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
            init     = rand_bits(3) + 1;
            periodic = rand_bits(1);
            op_write(csr_pkg::CSR_TCFG, 32'hffff_ffff, {init, periodic, 1'b1});
            wait_timer_int(100);
            repeat (3) begin
                next_cycle();
                check_read(csr_pkg::CSR_TVAL);
                check_read(csr_pkg::CSR_ESTAT);
                check_value("timer_int", rvalue[`CSR_ESTAT_IS_TI], 32'b1);
            end
            op_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
            next_cycle();
            check_read(csr_pkg::CSR_ESTAT);
            if (periodic) begin
                wait_timer_int(100);
            end else begin
                repeat (4) begin
                    next_cycle();
                    check_read(csr_pkg::CSR_TVAL);
                end
            end
        end

        next_cycle();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+src
src/csr_pkg.sv
src/csr_exc_regs.sv
src/csr_timer.sv
src/csr_save_bank.sv
src/csr_top.sv
tests/csr_tb.sv
